// File: rtl/icache_csr.sv
`timescale 1ns/100ps
`default_nettype none

module icache_csr #(
    parameter int CNT_WIDTH = 16
) (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        cfg_wr,
    input  wire logic [1:0]  cfg_addr,
    input  wire logic [31:0] cfg_wdata,
    output logic [31:0]      cfg_rdata,
    input  wire logic        hit_seen,
    input  wire logic        miss_seen,
    output logic             enable,
    output logic             invalidate
);

    logic                 ctrl_wr;
    logic [1:0]           seen;
    logic [CNT_WIDTH-1:0] cnt_q [2]; // 0 hits, 1 misses

    assign ctrl_wr    = cfg_wr && (cfg_addr == 2'd0);
    assign invalidate = ctrl_wr && cfg_wdata[1]; // one-cycle strobe
    assign seen       = {miss_seen, hit_seen};

    always_ff @(posedge clk) begin
        if (rst) begin
            enable <= 1'b0;
        end else if (ctrl_wr) begin
            enable <= cfg_wdata[0];
        end
    end

    // saturating event counters
    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            if (rst || invalidate) begin
                cnt_q[i] <= '0;
            end else if (seen[i] && (cnt_q[i] != '1)) begin
                cnt_q[i] <= cnt_q[i] + 1'b1;
            end
        end
    end

    always_comb begin
        case (cfg_addr)
            2'd0:    cfg_rdata = {31'b0, enable}; // invalidate reads back 0
            2'd1:    cfg_rdata = 32'(cnt_q[0]);
            2'd2:    cfg_rdata = 32'(cnt_q[1]);
            default: cfg_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/icache_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module icache_ctrl (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire icache_pkg::fetch_req_t fetch,
    output icache_pkg::fetch_rsp_t      fetch_rsp,
    output icache_pkg::mem_req_t        mem_req,
    input  wire icache_pkg::mem_rsp_t   mem_rsp,
    input  wire icache_pkg::lookup_t    lookup,
    input  wire logic [31:0]            hit_data,
    input  wire logic                   enable,
    output icache_pkg::fill_t           fill,
    output logic                        touch,
    output logic                        miss_start
);
    import icache_pkg::*;

    typedef enum logic {
        ST_IDLE,
        ST_READ_MEM
    } state_e;

    state_e state_q;
    logic   addr_rcv_q; // memory took the address, waiting for data
    logic   fill_en_q;  // miss started with the cache enabled

    // saved at miss start
    logic [ICACHE_TAG_W-1:0]   tag_q;
    logic [ICACHE_INDEX_W-1:0] index_q;
    logic                      victim_q;

    logic        in_rm;
    logic        serve_hit;
    logic        go_mem;
    logic        read_done;
    fetch_addr_u mem_addr;

    assign in_rm     = (state_q == ST_READ_MEM);
    assign serve_hit = (state_q == ST_IDLE) && fetch.req && enable && lookup.hit;
    assign go_mem    = (state_q == ST_IDLE) && fetch.req && !(enable && lookup.hit);
    assign read_done = in_rm && mem_rsp.data_ok;

    always_comb begin
        mem_addr.f.tag    = tag_q;
        mem_addr.f.index  = index_q;
        mem_addr.f.offset = fetch.addr.f.offset; // core holds addr until data_ok
    end

    always_comb begin
        mem_req.req  = in_rm && !addr_rcv_q;
        mem_req.addr = mem_addr.word;

        fetch_rsp.addr_ok = serve_hit || (mem_req.req && mem_rsp.addr_ok);
        fetch_rsp.data_ok = serve_hit || read_done;
        fetch_rsp.rdata   = in_rm ? mem_rsp.rdata : hit_data;

        fill.valid = read_done && fill_en_q; // bypass reads fill nothing
        fill.way   = victim_q;
        fill.index = index_q;
        fill.tag   = tag_q;

        touch      = serve_hit;
        miss_start = go_mem && enable;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= ST_IDLE;
            addr_rcv_q <= 1'b0;
            fill_en_q  <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (go_mem) begin
                        state_q   <= ST_READ_MEM;
                        fill_en_q <= enable;
                    end
                end
                ST_READ_MEM: begin
                    if (read_done) state_q <= ST_IDLE;
                end
                default: state_q <= ST_IDLE;
            endcase

            if (read_done) begin
                addr_rcv_q <= 1'b0;
            end else if (mem_req.req && mem_rsp.addr_ok) begin
                addr_rcv_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (go_mem) begin
            tag_q    <= fetch.addr.f.tag;
            index_q  <= fetch.addr.f.index;
            victim_q <= lookup.victim_way;
        end
    end

endmodule

`default_nettype wire

// File: rtl/icache_data_store.sv
`timescale 1ns/100ps
`default_nettype none

module icache_data_store (
    input  wire logic                    clk,
    input  wire icache_pkg::fetch_addr_u addr,
    input  wire logic                    way,
    input  wire icache_pkg::fill_t       fill,
    input  wire logic [31:0]             wdata,
    output logic [31:0]                  rdata
);
    import icache_pkg::*;

    // one instruction word per line, two ways
    logic [31:0] words_q [2][ICACHE_SETS];

    // async read, way picked by the tag compare
    assign rdata = words_q[way][addr.f.index];

    // fill writes the word returned by memory
    always_ff @(posedge clk) begin
        if (fill.valid) begin
            words_q[fill.way][fill.index] <= wdata;
        end
    end

endmodule

`default_nettype wire

// File: rtl/icache_pkg.sv
`default_nettype none

package icache_pkg;

    // cache geometry, one 32-bit word per line
    localparam int ICACHE_INDEX_W  = 6;
    localparam int ICACHE_OFFSET_W = 2;
    localparam int ICACHE_TAG_W    = 32 - ICACHE_INDEX_W - ICACHE_OFFSET_W;
    localparam int ICACHE_SETS     = 1 << ICACHE_INDEX_W;

    typedef struct packed {
        logic [ICACHE_TAG_W-1:0]    tag;
        logic [ICACHE_INDEX_W-1:0]  index;
        logic [ICACHE_OFFSET_W-1:0] offset;
    } addr_fields_t;

    // raw word for the memory side, fields for lookup
    typedef union packed {
        logic [31:0]  word;
        addr_fields_t f;
    } fetch_addr_u;

    typedef struct packed {
        logic        req;
        fetch_addr_u addr;
    } fetch_req_t;

    typedef struct packed {
        logic        addr_ok;
        logic        data_ok;
        logic [31:0] rdata;
    } fetch_rsp_t;

    typedef struct packed {
        logic        req;
        logic [31:0] addr;
    } mem_req_t;

    typedef struct packed {
        logic        addr_ok;
        logic        data_ok;
        logic [31:0] rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic hit;
        logic hit_way;
        logic victim_way; // the way that is not MRU
    } lookup_t;

    typedef struct packed {
        logic                      valid;
        logic                      way;
        logic [ICACHE_INDEX_W-1:0] index;
        logic [ICACHE_TAG_W-1:0]   tag;
    } fill_t;

endpackage

`default_nettype wire

// File: rtl/icache_tag_store.sv
`timescale 1ns/100ps
`default_nettype none

module icache_tag_store (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire icache_pkg::fetch_addr_u addr,
    input  wire icache_pkg::fill_t       fill,
    input  wire logic                    touch,
    input  wire logic                    invalidate,
    output icache_pkg::lookup_t          lookup
);
    import icache_pkg::*;

    // valid and MRU are control state, tags are plain storage
    logic [1:0][ICACHE_SETS-1:0] valid_q;
    logic [ICACHE_SETS-1:0]      mru_q;   // 1 means way 1 used last
    logic [ICACHE_TAG_W-1:0]     tag_q [2][ICACHE_SETS];

    logic [ICACHE_INDEX_W-1:0] idx;
    logic [1:0]                way_hit;

    assign idx = addr.f.index;

    // compare both ways of the live set
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = valid_q[w][idx] && (tag_q[w][idx] == addr.f.tag);
        end
    end

    always_comb begin
        lookup.hit        = |way_hit;
        lookup.hit_way    = ~way_hit[0]; // way 0 wins, don't care on a miss
        lookup.victim_way = ~mru_q[idx];
    end

    always_ff @(posedge clk) begin
        if (rst || invalidate) begin
            valid_q <= '0;
            mru_q   <= '0;
        end else if (fill.valid) begin
            valid_q[fill.way][fill.index] <= 1'b1;
            mru_q[fill.index]             <= fill.way; // new line is MRU
        end else if (touch) begin
            mru_q[idx] <= lookup.hit_way;
        end
    end

    // tag written together with the valid bit
    always_ff @(posedge clk) begin
        if (fill.valid) begin
            tag_q[fill.way][fill.index] <= fill.tag;
        end
    end

endmodule

`default_nettype wire

// File: rtl/icache_top.sv
`timescale 1ns/100ps
`default_nettype none

module icache_top #(
    parameter int CNT_WIDTH = 16
) (
    input  wire logic                   clk,
    input  wire logic                   rst,
    // core fetch port
    input  wire icache_pkg::fetch_req_t fetch,
    output icache_pkg::fetch_rsp_t      fetch_rsp,
    // memory port
    output icache_pkg::mem_req_t        mem_req,
    input  wire icache_pkg::mem_rsp_t   mem_rsp,
    // configuration
    input  wire logic                   cfg_wr,
    input  wire logic [1:0]             cfg_addr,
    input  wire logic [31:0]            cfg_wdata,
    output logic [31:0]                 cfg_rdata
);
    import icache_pkg::*;

    lookup_t     lookup;
    fill_t       fill;
    logic        touch;
    logic        miss_start;
    logic [31:0] hit_data;
    logic        enable;
    logic        invalidate;

    icache_tag_store i_tag_store (
        .clk        (clk),
        .rst        (rst),
        .addr       (fetch.addr),
        .fill       (fill),
        .touch      (touch),
        .invalidate (invalidate),
        .lookup     (lookup)
    );

    // word comes from the way that matched
    icache_data_store i_data_store (
        .clk   (clk),
        .addr  (fetch.addr),
        .way   (lookup.hit_way),
        .fill  (fill),
        .wdata (mem_rsp.rdata),
        .rdata (hit_data)
    );

    icache_ctrl i_ctrl (
        .clk        (clk),
        .rst        (rst),
        .fetch      (fetch),
        .fetch_rsp  (fetch_rsp),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp),
        .lookup     (lookup),
        .hit_data   (hit_data),
        .enable     (enable),
        .fill       (fill),
        .touch      (touch),
        .miss_start (miss_start)
    );

    icache_csr #(
        .CNT_WIDTH (CNT_WIDTH)
    ) i_csr (
        .clk        (clk),
        .rst        (rst),
        .cfg_wr     (cfg_wr),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .cfg_rdata  (cfg_rdata),
        .hit_seen   (touch),      // served hits only
        .miss_seen  (miss_start),
        .enable     (enable),
        .invalidate (invalidate)
    );

endmodule

`default_nettype wire

// File: sim/icache_mem_model.sv
`timescale 1ns/100ps
`default_nettype none

module icache_mem_model #(
    parameter logic [31:0] DATA_KEY = 32'h0
) (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire icache_pkg::mem_req_t mem_req,
    output icache_pkg::mem_rsp_t      mem_rsp
);

    integer      seed;
    int          addr_dly;
    int          data_dly;
    logic [31:0] addr_q;

    // one read at a time, each with its own random delays
    initial begin
        seed    = 32'hbfe5a8f9;
        mem_rsp <= '0;
        forever begin
            @(posedge clk);
            if (!rst && mem_req.req === 1'b1) begin
                addr_q   = mem_req.addr;
                addr_dly = $unsigned($random(seed)) % 4;     // 0 to 3 cycles
                data_dly = 1 + $unsigned($random(seed)) % 4; // 1 to 4 cycles
                repeat (addr_dly) @(posedge clk);
                mem_rsp.addr_ok <= 1'b1;
                @(posedge clk);
                mem_rsp.addr_ok <= 1'b0;
                repeat (data_dly - 1) @(posedge clk);
                mem_rsp.data_ok <= 1'b1;
                mem_rsp.rdata   <= addr_q ^ DATA_KEY; // data follows the address
                @(posedge clk);
                mem_rsp.data_ok <= 1'b0;
                mem_rsp.rdata   <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: sim/tb_icache.sv
`timescale 1ns/100ps
`default_nettype none

module tb_icache;
    import icache_pkg::*;

    localparam int          CLK_PERIOD   = 8;
    localparam logic [31:0] DATA_KEY     = 32'h5a5a_c3c3;
    localparam int          ACCESSES     = 240;
    localparam int          MAX_MISS_CYC = 12;
    // every access treated as a slow miss, then doubled
    localparam int          TIMEOUT_NS   = ACCESSES * MAX_MISS_CYC * CLK_PERIOD * 2;

    logic        clk;
    logic        rst;
    fetch_req_t  fetch;
    fetch_rsp_t  fetch_rsp;
    mem_req_t    mem_req;
    mem_rsp_t    mem_rsp;
    logic        cfg_wr;
    logic [1:0]  cfg_addr;
    logic [31:0] cfg_wdata;
    logic [31:0] cfg_rdata;

    // reference cache state
    logic                    model_valid [2][ICACHE_SETS];
    logic [ICACHE_TAG_W-1:0] model_tag [2][ICACHE_SETS];
    logic                    model_mru [ICACHE_SETS];
    int                      model_hits;
    int                      model_misses;
    logic                    model_enable;
    int                      errors;
    integer                  seed;

    icache_top #(.CNT_WIDTH(16)) i_dut (
        .clk(clk), .rst(rst), .fetch(fetch), .fetch_rsp(fetch_rsp),
        .mem_req(mem_req), .mem_rsp(mem_rsp), .cfg_wr(cfg_wr),
        .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata)
    );

    icache_mem_model #(.DATA_KEY(DATA_KEY)) i_mem (
        .clk(clk), .rst(rst), .mem_req(mem_req), .mem_rsp(mem_rsp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic report_error(input string msg);
        errors++;
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            report_error($sformatf("ERR %s got %h exp %h", name, got, exp));
        end
    endtask

    task automatic compare_mem_req(input mem_req_t got, input mem_req_t exp);
        if (got !== exp) begin
            report_error($sformatf("ERR mem_req got req %h addr %h exp req %h addr %h",
                                   got.req, got.addr, exp.req, exp.addr));
        end
    endtask

    task automatic clear_model();
        for (int s = 0; s < ICACHE_SETS; s++) begin
            model_valid[0][s] = 1'b0;
            model_valid[1][s] = 1'b0;
            model_mru[s]      = 1'b0;
        end
        model_hits   = 0;
        model_misses = 0;
    endtask

    function automatic logic predict_hit(input logic [31:0] addr, output logic way);
        fetch_addr_u a;
        a.word = addr;
        way    = model_valid[0][a.f.index] && model_tag[0][a.f.index] == a.f.tag ? 1'b0 : 1'b1;
        return model_valid[way][a.f.index] && model_tag[way][a.f.index] == a.f.tag;
    endfunction

    // same victim rule as the cache: the way not used last
    task automatic record_access(input logic [31:0] addr);
        fetch_addr_u a;
        logic        way;
        logic        hit;
        a.word = addr;
        hit    = predict_hit(addr, way);
        if (model_enable) begin
            if (hit) begin
                model_mru[a.f.index] = way;
                model_hits++;
            end else begin
                way = ~model_mru[a.f.index];
                model_valid[way][a.f.index] = 1'b1;
                model_tag[way][a.f.index]   = a.f.tag;
                model_mru[a.f.index]        = way;
                model_misses++;
            end
        end
    endtask

    task automatic write_cfg(input logic [1:0] a, input logic [31:0] d);
        @(posedge clk);
        cfg_wr    <= 1'b1;
        cfg_addr  <= a;
        cfg_wdata <= d;
        @(posedge clk);
        cfg_wr <= 1'b0;
        if (a == 2'd0) begin
            model_enable = d[0];
            if (d[1]) clear_model();
        end
    endtask

    task automatic read_cfg_expect(input logic [1:0] a, input logic [31:0] exp);
        @(posedge clk);
        cfg_addr <= a;
        @(negedge clk);
        compare_word($sformatf("cfg_rdata[%0d]", a), cfg_rdata, exp);
    endtask

    task automatic check_counters(input int hits, input int misses);
        read_cfg_expect(2'd1, 32'(hits));
        read_cfg_expect(2'd2, 32'(misses));
    endtask

    // one fetch, held until data_ok, checked against the reference model
    task automatic access(input logic [31:0] addr, output logic got_hit);
        logic     way;
        logic     exp_hit;
        logic     addr_taken;
        mem_req_t exp_req;
        exp_hit      = model_enable && predict_hit(addr, way);
        addr_taken   = 1'b0;
        exp_req.req  = 1'b1;
        exp_req.addr = addr;
        @(posedge clk);
        fetch.req  <= 1'b1;
        fetch.addr <= addr;
        @(negedge clk);
        got_hit = fetch_rsp.data_ok;
        if (got_hit !== exp_hit) begin
            report_error($sformatf("fetch of %h: hit was %b but the model says %b",
                                   addr, got_hit, exp_hit));
        end
        if (got_hit) begin
            if (mem_req.req !== 1'b0) report_error("memory request issued on a cache hit");
            if (fetch_rsp.addr_ok !== 1'b1) report_error("addr_ok missing on a cache hit");
        end else begin
            while (fetch_rsp.data_ok !== 1'b1) begin
                @(negedge clk);
                if (!addr_taken) begin
                    compare_mem_req(mem_req, exp_req); // held until memory takes it
                end else if (mem_req.req !== 1'b0) begin
                    report_error("memory request still raised after memory addr_ok");
                end
                if (fetch_rsp.addr_ok !== mem_rsp.addr_ok) begin
                    report_error("core addr_ok does not follow memory addr_ok");
                end
                if (mem_rsp.addr_ok === 1'b1) addr_taken = 1'b1;
            end
        end
        compare_word("fetch_rsp.rdata", fetch_rsp.rdata, addr ^ DATA_KEY);
        @(posedge clk);
        fetch.req <= 1'b0;
        record_access(addr);
    endtask

    task automatic reset_state_check();
        @(negedge clk);
        if (mem_req.req !== 1'b0) report_error("mem_req.req high after reset");
        if (fetch_rsp.addr_ok !== 1'b0 || fetch_rsp.data_ok !== 1'b0) begin
            report_error("core strobes high after reset");
        end
        read_cfg_expect(2'd0, 32'h0);
        check_counters(0, 0);
    endtask

    task automatic cold_miss_then_hit();
        logic h;
        write_cfg(2'd0, 32'h1);
        access(32'h0040_0010, h);
        if (h) report_error("first fetch hit in an empty cache");
        access(32'h0040_0010, h);
        if (!h) report_error("repeat fetch did not hit");
        check_counters(1, 1);
    endtask

    task automatic replacement_order();
        logic h;
        access(32'h0000_1040, h); // A
        access(32'h0000_2040, h); // B, same set
        access(32'h0000_1040, h); // A becomes MRU
        access(32'h0000_3040, h); // C evicts B
        access(32'h0000_1040, h);
        if (!h) report_error("line A was evicted although it was used last");
        access(32'h0000_2040, h);
        if (h) report_error("line B still hit after being replaced");
        check_counters(model_hits, model_misses);
    endtask

    task automatic invalidate_all();
        logic h;
        write_cfg(2'd0, 32'h3);
        read_cfg_expect(2'd0, 32'h1);
        check_counters(0, 0);
        access(32'h0040_0010, h);
        if (h) report_error("cached line still hit after invalidate");
    endtask

    task automatic disabled_bypass();
        logic h;
        int   hits_before;
        int   misses_before;
        hits_before   = model_hits;
        misses_before = model_misses;
        write_cfg(2'd0, 32'h0);
        repeat (3) access(32'h0040_0020, h);
        check_counters(hits_before, misses_before);
        write_cfg(2'd0, 32'h1);
        access(32'h0040_0020, h);
        if (h) report_error("bypass fetch left a line in the cache");
    endtask

    // 4 tags over sets 0 to 3
    task automatic random_run();
        logic [31:0] r;
        logic [31:0] addr;
        logic        h;
        for (int n = 0; n < 200; n++) begin
            r    = $random(seed);
            addr = {22'h000140, r[3:2], 4'b0000, r[1:0], 2'b00};
            access(addr, h);
        end
        check_counters(model_hits, model_misses);
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        fetch     = '0;
        cfg_wr    = 1'b0;
        cfg_addr  = 2'd0;
        cfg_wdata = '0;
        errors    = 0;
        seed      = 32'hbfe5a8f9;
        model_enable = 1'b0;
        clear_model();
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        reset_state_check();
        cold_miss_then_hit();
        replacement_order();
        invalidate_all();
        disabled_bypass();
        random_run();

        if (errors == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("TEST FAIL");
            $fatal(1);
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired, a fetch or memory read never completed");
        $display("TEST FAIL");
        $fatal(1);
    end

endmodule

`default_nettype wire

// File: sources.f
rtl/icache_pkg.sv
rtl/icache_tag_store.sv
rtl/icache_data_store.sv
rtl/icache_ctrl.sv
rtl/icache_csr.sv
rtl/icache_top.sv
sim/icache_mem_model.sv
sim/tb_icache.sv
